// ==== hw/cache_pkg.sv ====
//////////////////////////////
// shared widths, request structs and the L2 FSM state
// used by every module of the two-level data cache
//////////////////////////////
package cache_pkg;

    // processor word and cache block geometry
    localparam int WORD_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int ADDR_W     = 30;
    // two word-offset bits select one of four words
    localparam int OFF_W      = 2;
    localparam int BLK_ADDR_W = ADDR_W - OFF_W;

    //////////////////////////////
    // request bundles
    //////////////////////////////

    // one processor data access, word addressed
    typedef struct packed {
        logic                read;
        logic                write;
        logic [ADDR_W-1:0]   addr;
        logic [WORD_W-1:0]   wdata;
    } proc_req_t;

    // block transfer, L1 to L2 and L2 to memory
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [BLK_ADDR_W-1:0] addr;
        logic [BLOCK_W-1:0]    wdata;
    } blk_req_t;

    //////////////////////////////
    // L2 controller states
    //////////////////////////////

    typedef enum logic [1:0] {
        L2_IDLE      = 2'd0,
        L2_WRITEBACK = 2'd1,
        L2_READMEM   = 2'd2,
        L2_READY     = 2'd3
    } l2_state_e;

endpackage

// ==== hw/l1_cache.sv ====
//////////////////////////////
// direct-mapped write-back L1 data cache
// hit and stall are combinational from the processor request,
// misses are served by block requests to L2
//////////////////////////////
`timescale 1ns/10ps

module l1_cache #(
    parameter int L1_LINES = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cache_pkg::proc_req_t           proc_req_i,
    input  logic [cache_pkg::BLOCK_W-1:0]  l2_rdata_i,
    input  logic                           l2_ready_i,
    output logic [cache_pkg::WORD_W-1:0]   proc_rdata_o,
    output logic                           proc_stall_o,
    output cache_pkg::blk_req_t            l2_req_o
);

    localparam int IDX_W = $clog2(L1_LINES);
    localparam int TAG_W = cache_pkg::BLK_ADDR_W - IDX_W;

    // line state
    logic [L1_LINES-1:0]           valid_q;
    logic [L1_LINES-1:0]           dirty_q;
    logic [TAG_W-1:0]              tag_q  [L1_LINES];
    logic [cache_pkg::BLOCK_W-1:0] data_q [L1_LINES];

    // request decode
    logic [cache_pkg::BLK_ADDR_W-1:0] blk_addr;
    logic [IDX_W-1:0]                 idx;
    logic [TAG_W-1:0]                 req_tag;
    logic [cache_pkg::OFF_W-1:0]      off;
    logic                             access;
    logic                             hit;
    logic                             miss;
    logic                             wr_hit;
    logic                             fill;
    logic                             wb_done;
    logic [cache_pkg::BLOCK_W-1:0]    line;
    logic [cache_pkg::BLOCK_W-1:0]    merged;

    assign blk_addr = proc_req_i.addr[cache_pkg::ADDR_W-1:cache_pkg::OFF_W];
    assign off      = proc_req_i.addr[cache_pkg::OFF_W-1:0];
    assign idx      = blk_addr[IDX_W-1:0];
    assign req_tag  = blk_addr[cache_pkg::BLK_ADDR_W-1:IDX_W];
    assign access   = proc_req_i.read | proc_req_i.write;

    //////////////////////////////
    // hit, stall and word select
    //////////////////////////////

    assign line   = data_q[idx];
    assign hit    = valid_q[idx] && (tag_q[idx] == req_tag);
    assign miss   = access && !hit;
    assign wr_hit = hit && proc_req_i.write;

    assign proc_stall_o = miss;
    assign proc_rdata_o = line[off*cache_pkg::WORD_W +: cache_pkg::WORD_W];

    // write word merged into the current line
    always_comb begin
        merged = line;
        merged[off*cache_pkg::WORD_W +: cache_pkg::WORD_W] = proc_req_i.wdata;
    end

    // L2 answers: either the victim went down or the new block arrived
    assign wb_done = miss && dirty_q[idx] && l2_ready_i;
    assign fill    = miss && !dirty_q[idx] && l2_ready_i;

    //////////////////////////////
    // block requests to L2
    //////////////////////////////

    always_comb begin
        l2_req_o = '0;
        if (miss) begin
            if (dirty_q[idx]) begin
                // push the dirty victim first
                l2_req_o.write = 1'b1;
                l2_req_o.addr  = {tag_q[idx], idx};
                l2_req_o.wdata = line;
            end else begin
                l2_req_o.read = 1'b1;
                l2_req_o.addr = blk_addr;
            end
        end
    end

    //////////////////////////////
    // line state update
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (wr_hit) begin
                dirty_q[idx] <= 1'b1;
            end else if (fill) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end else if (wb_done) begin
                dirty_q[idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            data_q[idx] <= merged;
        end else if (fill) begin
            tag_q[idx]  <= req_tag;
            data_q[idx] <= l2_rdata_i;
        end
    end

endmodule

// ==== hw/l2_array.sv ====
//////////////////////////////
// L2 line storage with hit and victim lookup
// written under strobes from the L2 controller
//////////////////////////////
`timescale 1ns/10ps

module l2_array #(
    parameter int L2_LINES = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  cache_pkg::blk_req_t               l2_req_i,
    input  logic [cache_pkg::BLOCK_W-1:0]     mem_rdata_i,
    input  logic                              fill_en_i,
    input  logic                              l1_wr_en_i,
    input  logic                              clean_en_i,
    input  logic                              resp_load_i,
    output logic                              hit_o,
    output logic                              victim_dirty_o,
    output logic [cache_pkg::BLK_ADDR_W-1:0]  victim_addr_o,
    output logic [cache_pkg::BLOCK_W-1:0]     victim_data_o,
    output logic [cache_pkg::BLOCK_W-1:0]     l2_rdata_o
);

    localparam int IDX_W = $clog2(L2_LINES);
    localparam int TAG_W = cache_pkg::BLK_ADDR_W - IDX_W;

    logic [L2_LINES-1:0]           valid_q;
    logic [L2_LINES-1:0]           dirty_q;
    logic [TAG_W-1:0]              tag_q  [L2_LINES];
    logic [cache_pkg::BLOCK_W-1:0] data_q [L2_LINES];

    logic [IDX_W-1:0]              idx;
    logic [TAG_W-1:0]              req_tag;
    logic [cache_pkg::BLOCK_W-1:0] mem_rdata_q;
    logic [cache_pkg::BLOCK_W-1:0] rdata_q;

    assign idx     = l2_req_i.addr[IDX_W-1:0];
    assign req_tag = l2_req_i.addr[cache_pkg::BLK_ADDR_W-1:IDX_W];

    // lookup at the request index
    assign hit_o          = valid_q[idx] && (tag_q[idx] == req_tag);
    assign victim_dirty_o = valid_q[idx] && dirty_q[idx];
    assign victim_addr_o  = {tag_q[idx], idx};
    assign victim_data_o  = data_q[idx];
    assign l2_rdata_o     = rdata_q;

    // valid and dirty, a block write from L1 wins over a fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_en_i) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end
            if (clean_en_i) begin
                dirty_q[idx] <= 1'b0;
            end
            if (l1_wr_en_i) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[idx]  <= req_tag;
            data_q[idx] <= mem_rdata_q;
        end
        if (l1_wr_en_i) begin
            data_q[idx] <= l2_req_i.wdata;
        end
    end

    // memory block seen one cycle late, in step with the registered ready
    always_ff @(posedge clk) begin
        mem_rdata_q <= mem_rdata_i;
    end

    // response block for L1, valid with the ready pulse
    always_ff @(posedge clk) begin
        if (resp_load_i) begin
            rdata_q <= fill_en_i ? mem_rdata_q : data_q[idx];
        end
    end

endmodule

// ==== hw/l2_ctrl.sv ====
//////////////////////////////
// L2 controller FSM
// serves L1 block requests from the array or from slow memory,
// writing a dirty victim back before the refill
//////////////////////////////
`timescale 1ns/10ps

module l2_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  cache_pkg::blk_req_t               l2_req_i,
    input  logic                              hit_i,
    input  logic                              victim_dirty_i,
    input  logic [cache_pkg::BLK_ADDR_W-1:0]  victim_addr_i,
    input  logic [cache_pkg::BLOCK_W-1:0]     victim_data_i,
    input  logic                              mem_ready_i,
    output logic                              l2_ready_o,
    output cache_pkg::blk_req_t               mem_req_o,
    output logic                              fill_en_o,
    output logic                              l1_wr_en_o,
    output logic                              clean_en_o,
    output logic                              resp_load_o
);

    cache_pkg::l2_state_e state_q;
    cache_pkg::l2_state_e state_d;
    logic                 mem_ready_q;
    logic                 access;

    assign access = l2_req_i.read | l2_req_i.write;

    // one-cycle ready, the FSM always leaves L2_READY
    assign l2_ready_o = (state_q == cache_pkg::L2_READY);

    //////////////////////////////
    // next state and strobes
    //////////////////////////////

    always_comb begin
        state_d     = state_q;
        fill_en_o   = 1'b0;
        l1_wr_en_o  = 1'b0;
        clean_en_o  = 1'b0;
        resp_load_o = 1'b0;
        mem_req_o   = '0;

        case (state_q)
            cache_pkg::L2_IDLE: begin
                if (access) begin
                    if (hit_i) begin
                        resp_load_o = 1'b1;
                        l1_wr_en_o  = l2_req_i.write;
                        state_d     = cache_pkg::L2_READY;
                    end else if (victim_dirty_i) begin
                        state_d = cache_pkg::L2_WRITEBACK;
                    end else begin
                        state_d = cache_pkg::L2_READMEM;
                    end
                end
            end

            cache_pkg::L2_WRITEBACK: begin
                if (mem_ready_q) begin
                    // victim is in memory now
                    clean_en_o = 1'b1;
                    state_d    = cache_pkg::L2_READMEM;
                end else begin
                    mem_req_o.write = 1'b1;
                    mem_req_o.addr  = victim_addr_i;
                    mem_req_o.wdata = victim_data_i;
                end
            end

            cache_pkg::L2_READMEM: begin
                if (mem_ready_q) begin
                    fill_en_o   = 1'b1;
                    resp_load_o = 1'b1;
                    // L1 victim block lands on top of the refilled line
                    l1_wr_en_o  = l2_req_i.write;
                    state_d     = cache_pkg::L2_READY;
                end else begin
                    mem_req_o.read = 1'b1;
                    mem_req_o.addr = l2_req_i.addr;
                end
            end

            cache_pkg::L2_READY: begin
                state_d = cache_pkg::L2_IDLE;
            end

            default: begin
                state_d = cache_pkg::L2_IDLE;
            end
        endcase
    end

    //////////////////////////////
    // state and memory ready
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= cache_pkg::L2_IDLE;
            mem_ready_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_ready_q <= mem_ready_i;
        end
    end

endmodule

// ==== hw/cache_hier.sv ====
//////////////////////////////
// two-level data cache, processor port in, block memory port out
// L1_LINES and L2_LINES size the two levels
//////////////////////////////
`timescale 1ns/10ps

module cache_hier #(
    parameter int L1_LINES = 8,
    parameter int L2_LINES = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cache_pkg::proc_req_t           proc_req_i,
    output logic [cache_pkg::WORD_W-1:0]   proc_rdata_o,
    output logic                           proc_stall_o,
    output cache_pkg::blk_req_t            mem_req_o,
    input  logic [cache_pkg::BLOCK_W-1:0]  mem_rdata_i,
    input  logic                           mem_ready_i
);

    // L1 to L2
    cache_pkg::blk_req_t              l2_req;
    logic [cache_pkg::BLOCK_W-1:0]    l2_rdata;
    logic                             l2_ready;

    // L2 array to controller
    logic                             hit;
    logic                             victim_dirty;
    logic [cache_pkg::BLK_ADDR_W-1:0] victim_addr;
    logic [cache_pkg::BLOCK_W-1:0]    victim_data;
    logic                             fill_en;
    logic                             l1_wr_en;
    logic                             clean_en;
    logic                             resp_load;

    l1_cache #(
        .L1_LINES (L1_LINES)
    ) u_l1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_req_i   (proc_req_i),
        .l2_rdata_i   (l2_rdata),
        .l2_ready_i   (l2_ready),
        .proc_rdata_o (proc_rdata_o),
        .proc_stall_o (proc_stall_o),
        .l2_req_o     (l2_req)
    );

    l2_array #(
        .L2_LINES (L2_LINES)
    ) u_l2_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .l2_req_i       (l2_req),
        .mem_rdata_i    (mem_rdata_i),
        .fill_en_i      (fill_en),
        .l1_wr_en_i     (l1_wr_en),
        .clean_en_i     (clean_en),
        .resp_load_i    (resp_load),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr),
        .victim_data_o  (victim_data),
        .l2_rdata_o     (l2_rdata)
    );

    l2_ctrl u_l2_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .l2_req_i       (l2_req),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_addr_i  (victim_addr),
        .victim_data_i  (victim_data),
        .mem_ready_i    (mem_ready_i),
        .l2_ready_o     (l2_ready),
        .mem_req_o      (mem_req_o),
        .fill_en_o      (fill_en),
        .l1_wr_en_o     (l1_wr_en),
        .clean_en_o     (clean_en),
        .resp_load_o    (resp_load)
    );

endmodule

// ==== verif/cache_hier_props.sv ====
//////////////////////////////
// port protocol assertions for the cache hierarchy
// attached to cache_hier with bind
//////////////////////////////
`timescale 1ns/10ps

module cache_hier_props (
    input logic                 clk,
    input logic                 rst_n,
    input cache_pkg::proc_req_t proc_req_i,
    input logic                 proc_stall_o,
    input cache_pkg::blk_req_t  mem_req_o,
    input logic                 mem_ready_i
);

    logic proc_busy;
    logic mem_busy;
    // failures so far, watched from the testbench
    int   fail_count = 0;

    assign proc_busy = proc_req_i.read | proc_req_i.write;
    assign mem_busy  = mem_req_o.read | mem_req_o.write;

    // memory port quiet right after reset
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !mem_busy)
    else begin
        $error("memory request active right after reset");
        fail_count++;
    end

    idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !proc_busy |-> !proc_stall_o)
    else begin
        $error("proc_stall_o high with no processor request");
        fail_count++;
    end

    mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req_o.read && mem_req_o.write))
    else begin
        $error("mem_req_o has read and write set together");
        fail_count++;
    end

    // request held and processor stalled until memory answers
    mem_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_busy && !mem_ready_i |=> $stable(mem_req_o) && proc_stall_o)
    else begin
        $error("mem_req_o changed or stall dropped before mem_ready_i");
        fail_count++;
    end

endmodule

bind cache_hier cache_hier_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .proc_req_i   (proc_req_i),
    .proc_stall_o (proc_stall_o),
    .mem_req_o    (mem_req_o),
    .mem_ready_i  (mem_ready_i)
);

// ==== verif/cache_hier_tb.sv ====
//////////////////////////////
// testbench for the two-level data cache
// drives the processor port and models a slow block memory
//////////////////////////////
`timescale 1ns/10ps

module cache_hier_tb;

    logic                          clk = 1'b0;
    logic                          rst_n;
    cache_pkg::proc_req_t          proc_req;
    logic [cache_pkg::WORD_W-1:0]  proc_rdata;
    logic                          proc_stall;
    cache_pkg::blk_req_t           mem_req;
    logic [cache_pkg::BLOCK_W-1:0] mem_rdata = '0;
    logic                          mem_ready = 1'b0;

    // written blocks and words, absent keys still hold the fill pattern
    logic [127:0] mem_blocks [logic [27:0]];
    logic [31:0]  ref_words  [logic [29:0]];
    int           seed = 32'hcf24;
    int           mem_writes = 0;

    cache_hier #(
        .L1_LINES (8),
        .L2_LINES (32)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_req_i   (proc_req),
        .proc_rdata_o (proc_rdata),
        .proc_stall_o (proc_stall),
        .mem_req_o    (mem_req),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // expected values
    //////////////////////////////

    function automatic logic [31:0] fill_word(logic [29:0] addr);
        return {2'b00, addr} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] expected_word(logic [29:0] addr);
        return ref_words.exists(addr) ? ref_words[addr] : fill_word(addr);
    endfunction

    function automatic logic [127:0] stored_block(logic [27:0] blk);
        logic [127:0] data;
        for (int w = 0; w < 4; w++) begin
            data[w*32 +: 32] = fill_word({blk, w[1:0]});
        end
        return mem_blocks.exists(blk) ? mem_blocks[blk] : data;
    endfunction

    task automatic report_error(string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        report_error($sformatf("CHECK FAILED at %0t ns: %s expected %h got %h",
                               $time, name, exp, act));
    endtask

    //////////////////////////////
    // slow memory model
    //////////////////////////////

    // one answer 1 to 8 cycles after a request is seen
    always begin
        int          delay;
        logic [29:0] waddr;
        @(negedge clk);
        if (mem_req.read || mem_req.write) begin
            delay = 1 + ($random(seed) & 7);
            repeat (delay) @(posedge clk);
            #2;
            mem_rdata = stored_block(mem_req.addr);
            mem_ready = 1'b1;
            if (mem_req.write) begin
                // a written-back block carries the newest value of each word
                for (int w = 0; w < 4; w++) begin
                    waddr = {mem_req.addr, w[1:0]};
                    assert (mem_req.wdata[w*32 +: 32] == expected_word(waddr))
                    else report_mismatch("mem_req_o.wdata", expected_word(waddr),
                                         mem_req.wdata[w*32 +: 32]);
                end
                mem_blocks[mem_req.addr] = mem_req.wdata;
                mem_writes++;
            end
            @(posedge clk);
            #2;
            mem_ready = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (DUT.u_props.fail_count != 0) begin
            report_error("a protocol assertion in cache_hier_props failed");
        end
    end

    //////////////////////////////
    // processor accesses
    //////////////////////////////

    // starts 2 ns after a rising edge and returns at the same point
    task automatic cpu_access(input logic is_write, input logic [29:0] addr,
                              input logic [31:0] wdata, input logic expect_hit);
        int waited;
        proc_req.read  = !is_write;
        proc_req.write = is_write;
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        waited = 0;
        @(negedge clk);
        if (expect_hit) begin
            assert (!proc_stall)
            else report_mismatch("proc_stall_o", 32'd0, {31'd0, proc_stall});
        end
        while (proc_stall) begin
            if (waited == 200) begin
                report_error("timeout waiting for proc_stall_o to fall");
            end
            waited++;
            @(negedge clk);
        end
        if (is_write) begin
            ref_words[addr] = wdata;
        end else begin
            assert (proc_rdata == expected_word(addr))
            else report_mismatch("proc_rdata_o", expected_word(addr), proc_rdata);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        int blk;
        int word;
        rst_n    = 1'b0;
        proc_req = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // read miss, then the same word again as a hit
        cpu_access(1'b0, 30'h9, '0, 1'b0);
        cpu_access(1'b0, 30'h9, '0, 1'b1);
        // one word written, the other three keep their values
        cpu_access(1'b1, 30'ha, 32'hdeadbeef, 1'b1);
        for (int w = 8; w < 12; w++) begin
            cpu_access(1'b0, 30'(w), '0, 1'b1);
        end

        // blocks 5, 37, 69 and 101 share one L1 line and one L2 line
        for (int i = 0; i < 80; i++) begin
            blk  = 5 + 32 * ($random(seed) & 3);
            word = blk * 4 + ($random(seed) & 3);
            if ($random(seed) & 1) begin
                cpu_access(1'b1, 30'(word), $random(seed), 1'b0);
            end else begin
                cpu_access(1'b0, 30'(word), '0, 1'b0);
            end
        end

        // every word of the conflicting blocks read back after eviction
        for (int b = 5; b < 128; b += 32) begin
            for (int w = 0; w < 4; w++) begin
                cpu_access(1'b0, 30'(b * 4 + w), '0, 1'b0);
            end
        end

        if (mem_writes == 0) begin
            report_error("no dirty block was written back to memory");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== cache_hier.f ====
hw/cache_pkg.sv
hw/l1_cache.sv
hw/l2_array.sv
hw/l2_ctrl.sv
hw/cache_hier.sv
verif/cache_hier_props.sv
verif/cache_hier_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache hierarchy testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module cache_hier_tb \
		-f cache_hier.f --Mdir obj_dir -o cache_hier_sim
	-./obj_dir/cache_hier_sim +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@grep -q "NO ERRORS" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
